//--- Makefile
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -j 0 --top-module pipeline_tb -f verilog.f \
		--Mdir $(BUILD_DIR) -o pipeline_tb
	./$(BUILD_DIR)/pipeline_tb

clean:
	rm -rf $(BUILD_DIR)

//--- design/execute.sv
`timescale 1ns/1ns

module execute (
  input  logic                    clock_i,
  input  logic                    rst_n_i,
  input  logic                    hold_i,
  id_ex_if.dst                    id_ex,
  ex_mem_if.src                   ex_mem,
  input  pipeline_pkg::word_t     wb_result_i,
  input  pipeline_pkg::reg_addr_t wb_dest_i,
  input  logic                    wb_valid_i
);
  import pipeline_pkg::*;

  fwd_t  a_fwd;
  fwd_t  b_fwd;
  word_t a_live;
  word_t b_live;
  word_t a_op;
  word_t b_op;
  word_t a_held_q;
  word_t b_held_q;
  logic  held_q;
  word_t alu_b;
  word_t result;

  // Youngest producer wins
  function automatic fwd_t fwd_pick(input logic used, input reg_addr_t src);
    fwd_t sel;
    sel = FWD_NONE;
    if (used && ex_mem.dest_valid && ex_mem.dest_reg == src) begin
      sel = FWD_EX_MEM;
    end else if (used && wb_valid_i && wb_dest_i == src) begin
      sel = FWD_MEM_WB;
    end
    return sel;
  endfunction

  function automatic word_t fwd_value(input fwd_t sel, input word_t id_val);
    case (sel)
      FWD_EX_MEM: return ex_mem.result;
      FWD_MEM_WB: return wb_result_i;
      default:    return id_val;
    endcase
  endfunction

  assign a_fwd  = fwd_pick(id_ex.a_valid, id_ex.a_reg);
  assign b_fwd  = fwd_pick(id_ex.b_valid, id_ex.b_reg);
  assign a_live = fwd_value(a_fwd, id_ex.a_val);
  assign b_live = fwd_value(b_fwd, id_ex.b_val);

  // MEM/WB drains during a memory stall, so keep what was seen on its first cycle
  assign a_op = held_q ? a_held_q : a_live;
  assign b_op = held_q ? b_held_q : b_live;

  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      held_q <= 1'b0;
    end else begin
      held_q <= hold_i;
    end
  end

  always_ff @(posedge clock_i) begin
    if (hold_i) begin
      a_held_q <= a_op;
      b_held_q <= b_op;
    end
  end

  // Loads and stores take base plus offset
  assign alu_b = id_ex.imm_sel ? id_ex.imm : b_op;

  always_comb begin
    case (id_ex.alu_op)
      ALU_ADD: result = a_op + alu_b;
      ALU_SUB: result = a_op - alu_b;
      ALU_AND: result = a_op & alu_b;
      ALU_OR:  result = a_op | alu_b;
      ALU_SLT: result = word_t'($signed(a_op) < $signed(alu_b));
      default: result = '0;
    endcase
  end

  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_mem.ls_op      <= LS_NONE;
      ex_mem.dest_valid <= 1'b0;
    end else if (!hold_i) begin
      ex_mem.ls_op      <= id_ex.ls_op;
      ex_mem.dest_valid <= id_ex.dest_valid;
    end
  end

  always_ff @(posedge clock_i) begin
    if (!hold_i) begin
      ex_mem.result     <= result;
      ex_mem.store_data <= b_op;
      ex_mem.dest_reg   <= id_ex.dest_reg;
    end
  end

endmodule

//--- design/idec.sv
`timescale 1ns/1ns
`include "pipeline_defines.svh"

module idec (
  input  logic                    clock_i,
  input  logic                    rst_n_i,
  input  pipeline_pkg::word_t     inst_i,
  input  logic                    hold_i,
  output pipeline_pkg::reg_addr_t rfile_rd_addr1_o,
  output pipeline_pkg::reg_addr_t rfile_rd_addr2_o,
  input  pipeline_pkg::word_t     rfile_rd_data1_i,
  input  pipeline_pkg::word_t     rfile_rd_data2_i,
  id_ex_if.src                    id_ex,
  ex_mem_if.peek                  ex_mem,
  output logic                    load_use_o
);
  import pipeline_pkg::*;

  logic [5:0] opcode;
  logic [5:0] funct;
  reg_addr_t  rs;
  reg_addr_t  rt;
  reg_addr_t  rd;
  word_t      imm_sext;
  alu_op_t    fn_op;
  logic       special_hit;
  alu_op_t    alu_op;
  ls_op_t     ls_op;
  logic       a_used;
  logic       b_used;
  logic       imm_sel;
  reg_addr_t  dest_reg;
  logic       dest_valid;
  word_t      a_val;
  word_t      b_val;

  assign opcode   = inst_i[31:26];
  assign rs       = inst_i[25:21];
  assign rt       = inst_i[20:16];
  assign rd       = inst_i[15:11];
  assign funct    = inst_i[5:0];
  assign imm_sext = {{(`PIP_XLEN-16){inst_i[15]}}, inst_i[15:0]};

  assign rfile_rd_addr1_o = rs;
  assign rfile_rd_addr2_o = rt;

  always_comb begin
    special_hit = 1'b1;
    fn_op       = ALU_ADD;
    case (funct)
      `PIP_FN_ADDU: fn_op = ALU_ADD;
      `PIP_FN_SUBU: fn_op = ALU_SUB;
      `PIP_FN_AND:  fn_op = ALU_AND;
      `PIP_FN_OR:   fn_op = ALU_OR;
      `PIP_FN_SLT:  fn_op = ALU_SLT;
      default:      special_hit = 1'b0;
    endcase
  end

  // Unknown encodings fall through as no-ops
  always_comb begin
    alu_op     = ALU_ADD;
    ls_op      = LS_NONE;
    a_used     = 1'b0;
    b_used     = 1'b0;
    imm_sel    = 1'b1;
    dest_reg   = rt;
    dest_valid = 1'b0;
    case (opcode)
      `PIP_OPC_SPECIAL: begin
        alu_op     = fn_op;
        a_used     = special_hit;
        b_used     = special_hit;
        imm_sel    = 1'b0;
        dest_reg   = rd;
        dest_valid = special_hit;
      end
      `PIP_OPC_ADDIU, `PIP_OPC_LW: begin
        ls_op      = (opcode == `PIP_OPC_LW) ? LS_LOAD : LS_NONE;
        a_used     = 1'b1;
        dest_valid = 1'b1;
      end
      `PIP_OPC_SW: begin
        ls_op  = LS_STORE;
        a_used = 1'b1;
        b_used = 1'b1;
      end
      default: ;
    endcase
  end

  // A result still sitting in EX/MEM is newer than the register file
  assign a_val = (ex_mem.dest_valid && ex_mem.dest_reg == rs) ? ex_mem.result : rfile_rd_data1_i;
  assign b_val = (ex_mem.dest_valid && ex_mem.dest_reg == rt) ? ex_mem.result : rfile_rd_data2_i;

  assign load_use_o = (id_ex.ls_op == LS_LOAD) && id_ex.dest_valid &&
                      ((a_used && rs == id_ex.dest_reg) || (b_used && rt == id_ex.dest_reg));

  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_ex.alu_op     <= ALU_ADD;
      id_ex.imm_sel    <= 1'b0;
      id_ex.ls_op      <= LS_NONE;
      id_ex.a_valid    <= 1'b0;
      id_ex.b_valid    <= 1'b0;
      id_ex.dest_valid <= 1'b0;
    end else if (!hold_i) begin
      id_ex.alu_op     <= alu_op;
      id_ex.imm_sel    <= imm_sel;
      // Bubble into EX on a load-use hazard
      id_ex.ls_op      <= load_use_o ? LS_NONE : ls_op;
      id_ex.a_valid    <= a_used & ~load_use_o;
      id_ex.b_valid    <= b_used & ~load_use_o;
      id_ex.dest_valid <= dest_valid & (dest_reg != '0) & ~load_use_o;
    end
  end

  always_ff @(posedge clock_i) begin
    if (!hold_i) begin
      id_ex.a_val    <= a_val;
      id_ex.b_val    <= b_val;
      id_ex.a_reg    <= rs;
      id_ex.b_reg    <= rt;
      id_ex.imm      <= imm_sext;
      id_ex.dest_reg <= dest_reg;
    end
  end

endmodule

//--- design/ifetch.sv
`timescale 1ns/1ns
`include "pipeline_defines.svh"

module ifetch (
  input  logic                clock_i,
  input  logic                rst_n_i,
  input  logic                stall_i,
  output pipeline_pkg::addr_t icache_addr_o,
  output logic                icache_rd_o,
  input  pipeline_pkg::word_t icache_data_i,
  input  logic                icache_waitrequest_i,
  output pipeline_pkg::word_t inst_o
);
  import pipeline_pkg::*;

  addr_t pc_q;
  word_t inst_q;
  logic  fetch_ok;

  // Sequential fetch only, so a read is always wanted
  assign icache_rd_o   = 1'b1;
  assign icache_addr_o = pc_q;
  assign fetch_ok      = icache_rd_o & ~icache_waitrequest_i;
  assign inst_o        = inst_q;

  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= `PIP_RESET_PC;
    end else if (fetch_ok && !stall_i) begin
      pc_q <= pc_q + addr_t'(4);
    end
  end

  // IF/ID register
  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      inst_q <= `PIP_NOP;
    end else if (!stall_i) begin
      if (fetch_ok) begin
        inst_q <= icache_data_i;
      end else begin
        // Cache still busy
        inst_q <= `PIP_NOP;
      end
    end
  end

endmodule

//--- design/mem_access.sv
`timescale 1ns/1ns

module mem_access (
  input  logic                    clock_i,
  input  logic                    rst_n_i,
  ex_mem_if.dst                   ex_mem,
  output pipeline_pkg::addr_t     dcache_addr_o,
  output logic                    dcache_rd_o,
  output logic                    dcache_wr_o,
  output pipeline_pkg::word_t     dcache_wr_data_o,
  output pipeline_pkg::be_t       dcache_wr_be_o,
  input  pipeline_pkg::word_t     dcache_data_i,
  input  logic                    dcache_waitrequest_i,
  output logic                    mem_stall_o,
  output pipeline_pkg::reg_addr_t rfile_wr_addr1_o,
  output logic                    rfile_wr_enable1_o,
  output pipeline_pkg::word_t     rfile_wr_data1_o
);
  import pipeline_pkg::*;

  logic      is_load;
  logic      is_store;
  logic      wb_valid_q;
  reg_addr_t wb_dest_q;
  word_t     wb_data_q;

  assign is_load  = (ex_mem.ls_op == LS_LOAD);
  assign is_store = (ex_mem.ls_op == LS_STORE);

  // EX/MEM is frozen while waiting, which keeps the request stable
  assign dcache_addr_o    = ex_mem.result;
  assign dcache_rd_o      = is_load;
  assign dcache_wr_o      = is_store;
  assign dcache_wr_data_o = ex_mem.store_data;
  assign dcache_wr_be_o   = '1;

  assign mem_stall_o = (is_load | is_store) & dcache_waitrequest_i;

  // MEM/WB register
  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_valid_q <= 1'b0;
    end else begin
      // Bubble to write-back while stalled
      wb_valid_q <= ex_mem.dest_valid & ~mem_stall_o;
    end
  end

  always_ff @(posedge clock_i) begin
    wb_dest_q <= ex_mem.dest_reg;
    wb_data_q <= is_load ? dcache_data_i : ex_mem.result;
  end

  // Write-back
  assign rfile_wr_addr1_o   = wb_dest_q;
  assign rfile_wr_enable1_o = wb_valid_q;
  assign rfile_wr_data1_o   = wb_data_q;

endmodule

//--- design/pipeline.sv
`timescale 1ns/1ns

module pipeline (
  input  logic                    clock_i,
  input  logic                    rst_n_i,

  output pipeline_pkg::addr_t     icache_addr_o,
  output logic                    icache_rd_o,
  input  pipeline_pkg::word_t     icache_data_i,
  input  logic                    icache_waitrequest_i,

  output pipeline_pkg::reg_addr_t rfile_rd_addr1_o,
  output pipeline_pkg::reg_addr_t rfile_rd_addr2_o,
  input  pipeline_pkg::word_t     rfile_rd_data1_i,
  input  pipeline_pkg::word_t     rfile_rd_data2_i,

  output pipeline_pkg::addr_t     dcache_addr_o,
  output logic                    dcache_rd_o,
  output logic                    dcache_wr_o,
  output pipeline_pkg::word_t     dcache_wr_data_o,
  output pipeline_pkg::be_t       dcache_wr_be_o,
  input  pipeline_pkg::word_t     dcache_data_i,
  input  logic                    dcache_waitrequest_i,

  output pipeline_pkg::reg_addr_t rfile_wr_addr1_o,
  output logic                    rfile_wr_enable1_o,
  output pipeline_pkg::word_t     rfile_wr_data1_o
);
  import pipeline_pkg::*;

  word_t if_inst;
  logic  mem_stall;
  logic  load_use;
  logic  stall_if;

  // Load-use freezes only the front end, a memory wait freezes up to MEM
  assign stall_if = mem_stall | load_use;

  id_ex_if  id_ex0 ();
  ex_mem_if ex_mem0 ();

  ifetch ifetch0 (
    .clock_i              (clock_i),
    .rst_n_i              (rst_n_i),
    .stall_i              (stall_if),
    .icache_addr_o        (icache_addr_o),
    .icache_rd_o          (icache_rd_o),
    .icache_data_i        (icache_data_i),
    .icache_waitrequest_i (icache_waitrequest_i),
    .inst_o               (if_inst)
  );

  idec idec0 (
    .clock_i          (clock_i),
    .rst_n_i          (rst_n_i),
    .inst_i           (if_inst),
    .hold_i           (mem_stall),
    .rfile_rd_addr1_o (rfile_rd_addr1_o),
    .rfile_rd_addr2_o (rfile_rd_addr2_o),
    .rfile_rd_data1_i (rfile_rd_data1_i),
    .rfile_rd_data2_i (rfile_rd_data2_i),
    .id_ex            (id_ex0.src),
    .ex_mem           (ex_mem0.peek),
    .load_use_o       (load_use)
  );

  execute execute0 (
    .clock_i     (clock_i),
    .rst_n_i     (rst_n_i),
    .hold_i      (mem_stall),
    .id_ex       (id_ex0.dst),
    .ex_mem      (ex_mem0.src),
    .wb_result_i (rfile_wr_data1_o),
    .wb_dest_i   (rfile_wr_addr1_o),
    .wb_valid_i  (rfile_wr_enable1_o)
  );

  mem_access mem_access0 (
    .clock_i              (clock_i),
    .rst_n_i              (rst_n_i),
    .ex_mem               (ex_mem0.dst),
    .dcache_addr_o        (dcache_addr_o),
    .dcache_rd_o          (dcache_rd_o),
    .dcache_wr_o          (dcache_wr_o),
    .dcache_wr_data_o     (dcache_wr_data_o),
    .dcache_wr_be_o       (dcache_wr_be_o),
    .dcache_data_i        (dcache_data_i),
    .dcache_waitrequest_i (dcache_waitrequest_i),
    .mem_stall_o          (mem_stall),
    .rfile_wr_addr1_o     (rfile_wr_addr1_o),
    .rfile_wr_enable1_o   (rfile_wr_enable1_o),
    .rfile_wr_data1_o     (rfile_wr_data1_o)
  );

endmodule

//--- design/pipeline_pkg.sv
`include "pipeline_defines.svh"

package pipeline_pkg;

  typedef logic [`PIP_XLEN-1:0]   word_t;
  typedef logic [`PIP_XLEN-1:0]   addr_t;
  typedef logic [`PIP_REG_AW-1:0] reg_addr_t;
  typedef logic [`PIP_BE_W-1:0]   be_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } alu_op_t;

  // Where an EX operand comes from
  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_EX_MEM,
    FWD_MEM_WB
  } fwd_t;

  typedef enum logic [1:0] {
    LS_NONE,
    LS_LOAD,
    LS_STORE
  } ls_op_t;

endpackage

//--- design/stage_ifs.sv
`timescale 1ns/1ns

// ID/EX pipeline register
interface id_ex_if;
  import pipeline_pkg::*;

  word_t     a_val;
  word_t     b_val;
  reg_addr_t a_reg;
  reg_addr_t b_reg;
  logic      a_valid;
  logic      b_valid;
  word_t     imm;
  logic      imm_sel;
  alu_op_t   alu_op;
  ls_op_t    ls_op;
  reg_addr_t dest_reg;
  logic      dest_valid;

  modport src (
    output a_val, b_val, a_reg, b_reg, a_valid, b_valid, imm, imm_sel,
           alu_op, ls_op, dest_reg, dest_valid
  );
  modport dst (
    input a_val, b_val, a_reg, b_reg, a_valid, b_valid, imm, imm_sel,
          alu_op, ls_op, dest_reg, dest_valid
  );
endinterface

// EX/MEM pipeline register
interface ex_mem_if;
  import pipeline_pkg::*;

  word_t     result;
  word_t     store_data;
  ls_op_t    ls_op;
  reg_addr_t dest_reg;
  logic      dest_valid;

  modport src (output result, store_data, ls_op, dest_reg, dest_valid);
  modport dst (input result, store_data, ls_op, dest_reg, dest_valid);
  modport peek (input result, dest_reg, dest_valid);
endinterface

//--- include/pipeline_defines.svh
`ifndef PIPELINE_DEFINES_SVH
`define PIPELINE_DEFINES_SVH

// Datapath widths
`define PIP_XLEN      32
`define PIP_REG_AW    5
`define PIP_BE_W      4

`define PIP_RESET_PC  32'h0000_0000
// Encodes sll $0,$0,0
`define PIP_NOP       32'h0000_0000

// Primary opcodes
`define PIP_OPC_SPECIAL 6'h00
`define PIP_OPC_ADDIU   6'h09
`define PIP_OPC_LW      6'h23
`define PIP_OPC_SW      6'h2b

// SPECIAL funct field
`define PIP_FN_ADDU   6'h21
`define PIP_FN_SUBU   6'h23
`define PIP_FN_AND    6'h24
`define PIP_FN_OR     6'h25
`define PIP_FN_SLT    6'h2a

`endif

//--- verification/pipeline_tb.sv
`timescale 1ns/1ns
`include "pipeline_defines.svh"

module pipeline_tb;

  localparam int MAX_ENTRIES      = 64;
  localparam int RESET_CYCLES     = 4;
  localparam int DRAIN_CYCLES     = 20;
  // Generous bound per entry under random wait-requests
  localparam int CYCLES_PER_ENTRY = 16;
  localparam int EFF_NONE         = 0;
  localparam int EFF_REG          = 1;
  localparam int EFF_STORE        = 2;

  logic        clock;
  logic        rst_n;
  logic [31:0] icache_addr;
  logic        icache_rd;
  logic [31:0] icache_data;
  logic        icache_wait;
  logic [4:0]  rd_addr1;
  logic [4:0]  rd_addr2;
  logic [31:0] rd_data1;
  logic [31:0] rd_data2;
  logic [31:0] dcache_addr;
  logic        dcache_rd;
  logic        dcache_wr;
  logic [31:0] dcache_wr_data;
  logic [3:0]  dcache_wr_be;
  logic [31:0] dcache_data;
  logic        dcache_wait;
  logic [4:0]  wr_addr;
  logic        wr_en;
  logic [31:0] wr_data;

  // Program table with the expected effect of each instruction
  logic [31:0] prog_inst [MAX_ENTRIES];
  int          exp_kind  [MAX_ENTRIES];
  logic [31:0] exp_where [MAX_ENTRIES];
  logic [31:0] exp_value [MAX_ENTRIES];
  int          n_entries;

  logic [31:0] regs [32];
  logic [31:0] ram [64];

  // Write-backs and stores as they were seen, in order
  int          obs_kind  [256];
  logic [31:0] obs_where [256];
  logic [31:0] obs_value [256];
  int          obs_count = 0;

  logic        random_wait;
  int          cycle_count = 0;
  int          cycle_limit;

  pipeline dut0 (
    .clock_i              (clock),
    .rst_n_i              (rst_n),
    .icache_addr_o        (icache_addr),
    .icache_rd_o          (icache_rd),
    .icache_data_i        (icache_data),
    .icache_waitrequest_i (icache_wait),
    .rfile_rd_addr1_o     (rd_addr1),
    .rfile_rd_addr2_o     (rd_addr2),
    .rfile_rd_data1_i     (rd_data1),
    .rfile_rd_data2_i     (rd_data2),
    .dcache_addr_o        (dcache_addr),
    .dcache_rd_o          (dcache_rd),
    .dcache_wr_o          (dcache_wr),
    .dcache_wr_data_o     (dcache_wr_data),
    .dcache_wr_be_o       (dcache_wr_be),
    .dcache_data_i        (dcache_data),
    .dcache_waitrequest_i (dcache_wait),
    .rfile_wr_addr1_o     (wr_addr),
    .rfile_wr_enable1_o   (wr_en),
    .rfile_wr_data1_o     (wr_data)
  );

  initial clock = 1'b0;
  always #5 clock = ~clock;

  // Instruction ROM gives no-ops past the program and while waiting
  assign icache_data = (icache_rd && !icache_wait && icache_addr < 32'd256) ?
                       prog_inst[icache_addr[7:2]] : `PIP_NOP;

  // Register file with write-through reads
  assign rd_data1 = (rd_addr1 == 5'd0) ? 32'd0 :
                    (wr_en && wr_addr == rd_addr1) ? wr_data : regs[rd_addr1];
  assign rd_data2 = (rd_addr2 == 5'd0) ? 32'd0 :
                    (wr_en && wr_addr == rd_addr2) ? wr_data : regs[rd_addr2];

  // Read data shows only on an accepted read
  assign dcache_data = (dcache_rd && !dcache_wait) ? ram[dcache_addr[7:2]] : 32'h0bad_0bad;

  always @(posedge clock) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
      for (int i = 0; i < 64; i++) begin
        ram[i] <= 32'h5a5a_0000 ^ (i << 2);
      end
    end else begin
      if (wr_en) begin
        regs[wr_addr] <= wr_data;
      end
      if (dcache_wr && !dcache_wait) begin
        ram[dcache_addr[7:2]] <= dcache_wr_data;
      end
    end
  end

  // Wait-request source for both caches
  initial begin
    void'($urandom(78184));
    icache_wait = 1'b0;
    dcache_wait = 1'b0;
    forever begin
      @(posedge clock);
      if (random_wait) begin
        icache_wait <= (($urandom % 4) == 0);
        dcache_wait <= (($urandom % 3) == 0);
      end else begin
        icache_wait <= 1'b0;
        dcache_wait <= 1'b0;
      end
    end
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("Verification failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // Effects are sampled mid-cycle
  always @(negedge clock) begin
    if (!rst_n) begin
      obs_count = 0;
      check("reset: register write enable", 32'd0, {31'd0, wr_en});
      check("reset: dcache read", 32'd0, {31'd0, dcache_rd});
      check("reset: dcache write", 32'd0, {31'd0, dcache_wr});
      check("reset: fetch address", 32'd0, icache_addr);
    end else begin
      // Older write-back ahead of a younger store
      if (wr_en) begin
        obs_kind[obs_count]  = EFF_REG;
        obs_where[obs_count] = {27'd0, wr_addr};
        obs_value[obs_count] = wr_data;
        obs_count = obs_count + 1;
      end
      if (dcache_wr && !dcache_wait) begin
        check("store byte enables", 32'h0000_000f, {28'd0, dcache_wr_be});
        obs_kind[obs_count]  = EFF_STORE;
        obs_where[obs_count] = dcache_addr;
        obs_value[obs_count] = dcache_wr_data;
        obs_count = obs_count + 1;
      end
      check("dcache read with write", 32'd0, {31'd0, dcache_rd & dcache_wr});
    end
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: expected effects still missing after %0d cycles", cycle_count);
      $display("Verification failed");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  function automatic logic [31:0] encode_r(input logic [5:0] funct, input int rd,
                                           input int rs, input int rt);
    return {`PIP_OPC_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
  endfunction

  function automatic logic [31:0] encode_i(input logic [5:0] opcode, input int rt,
                                           input int rs, input int imm);
    return {opcode, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  task automatic add_entry(input logic [31:0] inst, input int kind, input int where,
                           input logic [31:0] value);
    prog_inst[n_entries] = inst;
    exp_kind[n_entries]  = kind;
    exp_where[n_entries] = 32'(where);
    exp_value[n_entries] = value;
    n_entries = n_entries + 1;
  endtask

  task automatic build_table();
    n_entries = 0;
    for (int i = 0; i < MAX_ENTRIES; i++) begin
      prog_inst[i] = `PIP_NOP;
    end
    // ALU results and writes to register 0
    add_entry(encode_i(`PIP_OPC_ADDIU, 1, 0, 5), EFF_REG, 1, 32'h0000_0005);
    add_entry(encode_i(`PIP_OPC_ADDIU, 2, 0, -3), EFF_REG, 2, 32'hffff_fffd);
    add_entry(encode_i(`PIP_OPC_ADDIU, 3, 0, 'h0f0c), EFF_REG, 3, 32'h0000_0f0c);
    add_entry(encode_i(`PIP_OPC_ADDIU, 4, 0, 'h7ff0), EFF_REG, 4, 32'h0000_7ff0);
    add_entry(encode_r(`PIP_FN_ADDU, 5, 1, 2), EFF_REG, 5, 32'h0000_0002);
    add_entry(encode_r(`PIP_FN_SUBU, 6, 1, 2), EFF_REG, 6, 32'h0000_0008);
    add_entry(encode_r(`PIP_FN_AND, 7, 3, 4), EFF_REG, 7, 32'h0000_0f00);
    add_entry(encode_r(`PIP_FN_OR, 8, 3, 4), EFF_REG, 8, 32'h0000_7ffc);
    add_entry(encode_r(`PIP_FN_SLT, 9, 2, 1), EFF_REG, 9, 32'h0000_0001);
    add_entry(encode_r(`PIP_FN_SLT, 10, 1, 2), EFF_REG, 10, 32'h0000_0000);
    add_entry(encode_r(`PIP_FN_ADDU, 0, 1, 1), EFF_NONE, 0, 32'h0);
    add_entry(encode_i(`PIP_OPC_ADDIU, 0, 1, 7), EFF_NONE, 0, 32'h0);
    add_entry(encode_r(`PIP_FN_SUBU, 11, 4, 3), EFF_REG, 11, 32'h0000_70e4);
    // Dependent chains at distance 1 and 2
    add_entry(encode_i(`PIP_OPC_ADDIU, 12, 0, 'h11), EFF_REG, 12, 32'h0000_0011);
    add_entry(encode_r(`PIP_FN_ADDU, 13, 12, 12), EFF_REG, 13, 32'h0000_0022);
    add_entry(encode_r(`PIP_FN_SUBU, 14, 13, 12), EFF_REG, 14, 32'h0000_0011);
    add_entry(encode_r(`PIP_FN_OR, 15, 12, 13), EFF_REG, 15, 32'h0000_0033);
    add_entry(encode_i(`PIP_OPC_ADDIU, 16, 15, -1), EFF_REG, 16, 32'h0000_0032);
    add_entry(encode_r(`PIP_FN_SLT, 17, 16, 15), EFF_REG, 17, 32'h0000_0001);
    add_entry(encode_r(`PIP_FN_AND, 18, 16, 14), EFF_REG, 18, 32'h0000_0010);
    // Stores, then loads of stored and untouched words
    add_entry(encode_i(`PIP_OPC_ADDIU, 19, 0, 'h40), EFF_REG, 19, 32'h0000_0040);
    add_entry(encode_i(`PIP_OPC_SW, 13, 19, 4), EFF_STORE, 'h44, 32'h0000_0022);
    add_entry(encode_i(`PIP_OPC_SW, 8, 19, 0), EFF_STORE, 'h40, 32'h0000_7ffc);
    add_entry(encode_i(`PIP_OPC_LW, 20, 19, 4), EFF_REG, 20, 32'h0000_0022);
    add_entry(encode_i(`PIP_OPC_LW, 21, 19, 0), EFF_REG, 21, 32'h0000_7ffc);
    add_entry(encode_i(`PIP_OPC_LW, 22, 19, 8), EFF_REG, 22, 32'h5a5a_0048);
    add_entry(encode_i(`PIP_OPC_ADDIU, 23, 0, 'h1234), EFF_REG, 23, 32'h0000_1234);
    add_entry(encode_i(`PIP_OPC_SW, 23, 19, 12), EFF_STORE, 'h4c, 32'h0000_1234);
    add_entry(encode_i(`PIP_OPC_LW, 24, 19, -4), EFF_REG, 24, 32'h5a5a_003c);
    // Load followed right away by a use
    add_entry(encode_i(`PIP_OPC_LW, 25, 19, 12), EFF_REG, 25, 32'h0000_1234);
    add_entry(encode_r(`PIP_FN_ADDU, 26, 25, 12), EFF_REG, 26, 32'h0000_1245);
    add_entry(encode_i(`PIP_OPC_LW, 27, 19, 4), EFF_REG, 27, 32'h0000_0022);
    add_entry(encode_r(`PIP_FN_SUBU, 28, 12, 27), EFF_REG, 28, 32'hffff_ffef);
    add_entry(encode_i(`PIP_OPC_LW, 29, 19, 0), EFF_REG, 29, 32'h0000_7ffc);
    add_entry(encode_i(`PIP_OPC_SW, 29, 19, 16), EFF_STORE, 'h50, 32'h0000_7ffc);
    add_entry(encode_i(`PIP_OPC_LW, 30, 19, 16), EFF_REG, 30, 32'h0000_7ffc);
    add_entry(encode_i(`PIP_OPC_ADDIU, 31, 30, 1), EFF_REG, 31, 32'h0000_7ffd);
    // lui and sll are outside the subset
    add_entry(32'h3c01_1234, EFF_NONE, 0, 32'h0);
    add_entry(encode_r(6'h00, 2, 0, 1), EFF_NONE, 0, 32'h0);
    add_entry(encode_r(`PIP_FN_ADDU, 3, 1, 2), EFF_REG, 3, 32'h0000_0002);
    add_entry(encode_i(`PIP_OPC_LW, 4, 19, 4), EFF_REG, 4, 32'h0000_0022);
    add_entry(encode_i(`PIP_OPC_ADDIU, 5, 0, 1), EFF_REG, 5, 32'h0000_0001);
    add_entry(encode_r(`PIP_FN_ADDU, 6, 4, 5), EFF_REG, 6, 32'h0000_0023);
  endtask

  task automatic run_table(input string run_name, input logic use_wait);
    int taken;
    taken = 0;
    @(posedge clock);
    rst_n       <= 1'b0;
    random_wait <= use_wait;
    repeat (RESET_CYCLES) @(posedge clock);
    rst_n <= 1'b1;
    @(negedge clock);
    check($sformatf("%s: first fetch address", run_name), 32'd0, icache_addr);
    check($sformatf("%s: first fetch read", run_name), 32'd1, {31'd0, icache_rd});
    @(posedge clock);
    for (int i = 0; i < n_entries; i++) begin
      if (exp_kind[i] != EFF_NONE) begin
        while (obs_count <= taken) begin
          @(posedge clock);
        end
        check($sformatf("%s: entry %0d kind", run_name, i), exp_kind[i], obs_kind[taken]);
        check($sformatf("%s: entry %0d target", run_name, i), exp_where[i],
              obs_where[taken]);
        check($sformatf("%s: entry %0d value", run_name, i), exp_value[i],
              obs_value[taken]);
        taken = taken + 1;
      end
    end
    // Only no-ops remain, so nothing more may show up
    repeat (DRAIN_CYCLES) @(posedge clock);
    check($sformatf("%s: number of effects", run_name), taken, obs_count);
  endtask

  initial begin
    rst_n       = 1'b0;
    random_wait = 1'b0;
    build_table();
    cycle_limit = 2 * (RESET_CYCLES + 2 + DRAIN_CYCLES + n_entries * CYCLES_PER_ENTRY);
    run_table("no wait", 1'b0);
    run_table("random wait", 1'b1);
    $display("Verification passed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+include
design/pipeline_pkg.sv
design/stage_ifs.sv
design/ifetch.sv
design/idec.sv
design/execute.sv
design/mem_access.sv
design/pipeline.sv
verification/pipeline_tb.sv
